// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module rv_exec_tb -f rv_exec.f -o rv_exec_sim
./obj_dir/rv_exec_sim | tee sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
        exit 1
fi
exit 0

// File: rv_apb_slave.sv
module rv_apb_slave (
        input  logic                   i_clock,
        input  logic                   i_reset,
        input  logic                   i_psel,
        input  logic                   i_penable,
        input  logic                   i_pwrite,
        input  rv_exec_pkg::apb_addr_t i_paddr,
        input  rv_exec_pkg::xlen_t     i_pwdata,
        input  logic                   i_busy,
        output logic                   o_pready,
        output rv_exec_pkg::xlen_t     o_instr,
        output logic                   o_instr_valid,
        output logic                   o_view_req,
        output rv_exec_pkg::reg_idx_t  o_view_idx,
        output logic [1:0]             o_rd_sel
);
        typedef enum logic [1:0] {IDLE, WAIT_EXEC, WAIT_REG} apb_state_e;

        apb_state_e state, state_next;
        logic       access;
        logic       is_instr;
        logic       is_reg;

        assign access   = i_psel & i_penable;
        assign is_instr = i_pwrite & (i_paddr == rv_exec_pkg::ADDR_INSTR);
        assign is_reg   = ~i_pwrite &
                          ((i_paddr & ~12'h07f) == rv_exec_pkg::ADDR_REG_BASE);

        assign o_instr    = i_pwdata;
        assign o_view_idx = i_paddr[6:2];
        assign o_rd_sel   = is_reg ? rv_exec_pkg::SEL_REG :
                            (i_paddr == rv_exec_pkg::ADDR_RESULT) ? rv_exec_pkg::SEL_RESULT :
                            (i_paddr == rv_exec_pkg::ADDR_STATUS) ? rv_exec_pkg::SEL_STATUS :
                            rv_exec_pkg::SEL_NONE;

        always_comb begin
                state_next    = state;
                o_pready      = 1'b0;
                o_instr_valid = 1'b0;
                o_view_req    = 1'b0;
                case (state)
                IDLE: begin
                        if (access) begin
                                if (is_instr) begin
                                        if (i_busy) begin
                                                state_next = WAIT_EXEC;
                                        end else begin
                                                o_pready      = 1'b1;
                                                o_instr_valid = 1'b1;
                                        end
                                end else if (is_reg) begin
                                        o_view_req = 1'b1;   // View port answers next cycle
                                        state_next = WAIT_REG;
                                end else begin
                                        o_pready = 1'b1;
                                end
                        end
                end
                WAIT_EXEC: begin
                        if (access && !i_busy) begin
                                o_pready      = 1'b1;
                                o_instr_valid = 1'b1;
                                state_next    = IDLE;
                        end
                end
                WAIT_REG: begin
                        o_pready   = access;
                        state_next = IDLE;
                end
                default: state_next = IDLE;
                endcase
        end

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        state <= IDLE;
                end else begin
                        state <= state_next;
                end
        end

endmodule

// File: rv_decode.sv
module rv_decode (
        input  logic               i_clock,
        input  logic               i_reset,
        input  rv_exec_pkg::xlen_t i_instr,
        input  logic               i_instr_valid,
        exec_if.dec                o_exec,
        output logic               o_illegal
);
        logic [6:0] opcode;
        logic [6:0] funct7;
        logic [2:0] funct3;
        logic       is_op;
        logic       is_imm;
        logic       is_shift;
        logic       alt;
        logic       legal;

        assign opcode   = i_instr[6:0];
        assign funct3   = i_instr[14:12];
        assign funct7   = i_instr[31:25];
        assign is_op    = (opcode == 7'b0110011);
        assign is_imm   = (opcode == 7'b0010011);
        assign is_shift = (funct3 == 3'd1) || (funct3 == 3'd5);
        // SUB and SRA/SRAI take funct7[5]; for other immediates it is just imm bits
        assign alt      = funct7[5] & ((funct3 == 3'd5) | (is_op & (funct3 == 3'd0)));

        always_comb begin
                legal = 1'b0;
                if (is_op) begin
                        legal = (funct7 == 7'h00) ||
                                ((funct7 == 7'h20) && ((funct3 == 3'd0) || (funct3 == 3'd5)));
                end else if (is_imm) begin
                        if (funct3 == 3'd1)
                                legal = (funct7 == 7'h00);
                        else if (funct3 == 3'd5)
                                legal = (funct7 == 7'h00) || (funct7 == 7'h20);
                        else
                                legal = 1'b1;
                end
        end

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        o_exec.valid <= 1'b0;
                        o_illegal    <= 1'b0;
                end else begin
                        o_exec.valid <= i_instr_valid & legal & ~o_exec.busy;
                        o_illegal    <= i_instr_valid & ~legal;
                end
        end

        // Fields hold until the next accepted word
        always_ff @(posedge i_clock) begin
                if (i_instr_valid && !o_exec.busy) begin
                        o_exec.op      <= {alt, funct3};
                        o_exec.rd      <= i_instr[11:7];
                        o_exec.rs1     <= i_instr[19:15];
                        o_exec.rs2     <= i_instr[24:20];
                        o_exec.use_imm <= is_imm;
                        o_exec.imm     <= is_shift ? {27'b0, i_instr[24:20]}   // shamt
                                                   : {{20{i_instr[31]}}, i_instr[31:20]};
                end
        end

endmodule

// File: rv_exec.f
rv_exec_pkg.sv
rv_exec_if.sv
rv_apb_slave.sv
rv_decode.sv
rv_execute.sv
rv_regfile.sv
rv_readback.sv
rv_exec_top.sv
tb_clock.sv
rv_exec_props.sv
rv_exec_tb.sv

// File: rv_exec_if.sv
interface exec_if;

        logic                   valid;
        rv_exec_pkg::alu_op_t   op;
        rv_exec_pkg::reg_idx_t  rd;
        rv_exec_pkg::reg_idx_t  rs1;
        rv_exec_pkg::reg_idx_t  rs2;
        rv_exec_pkg::xlen_t     imm;
        logic                   use_imm;   // Second operand is imm, not rs2
        logic                   busy;

        modport dec (output valid, op, rd, rs1, rs2, imm, use_imm, input busy);
        modport exe (input valid, op, rd, rs1, rs2, imm, use_imm, output busy);

endinterface

interface rf_if;

        // Operand read, values valid the edge after read
        rv_exec_pkg::reg_idx_t  rs1_idx;
        rv_exec_pkg::reg_idx_t  rs2_idx;
        logic                   read;
        rv_exec_pkg::xlen_t     rs1;
        rv_exec_pkg::xlen_t     rs2;

        // Write-back
        rv_exec_pkg::reg_idx_t  wr_idx;
        rv_exec_pkg::xlen_t     wr_data;
        logic                   write;

        modport exe (output rs1_idx, rs2_idx, read, wr_idx, wr_data, write,
                     input rs1, rs2);
        modport rf (input rs1_idx, rs2_idx, read, wr_idx, wr_data, write,
                    output rs1, rs2);

endinterface

// File: rv_exec_pkg.sv
package rv_exec_pkg;

        typedef logic [31:0] xlen_t;
        typedef logic [4:0]  reg_idx_t;
        typedef logic [11:0] apb_addr_t;
        typedef logic [3:0]  alu_op_t;

        // ALU codes are {funct7[5], funct3}, so OP and OP-IMM map straight through
        localparam alu_op_t ALU_ADD  = 4'b0000;
        localparam alu_op_t ALU_SUB  = 4'b1000;
        localparam alu_op_t ALU_SLL  = 4'b0001;
        localparam alu_op_t ALU_SLT  = 4'b0010;
        localparam alu_op_t ALU_SLTU = 4'b0011;
        localparam alu_op_t ALU_XOR  = 4'b0100;
        localparam alu_op_t ALU_SRL  = 4'b0101;
        localparam alu_op_t ALU_SRA  = 4'b1101;
        localparam alu_op_t ALU_OR   = 4'b0110;
        localparam alu_op_t ALU_AND  = 4'b0111;

        // APB register map
        localparam apb_addr_t ADDR_INSTR    = 12'h000;
        localparam apb_addr_t ADDR_RESULT   = 12'h004;
        localparam apb_addr_t ADDR_STATUS   = 12'h008;
        localparam apb_addr_t ADDR_REG_BASE = 12'h080;   // xN at base + 4N

        // Read data select between slave and readback
        localparam logic [1:0] SEL_RESULT = 2'd0;
        localparam logic [1:0] SEL_STATUS = 2'd1;
        localparam logic [1:0] SEL_REG    = 2'd2;
        localparam logic [1:0] SEL_NONE   = 2'd3;   // Unmapped, reads zero

endpackage

// File: rv_exec_props.sv
module rv_exec_props (
        input logic                   i_clock,
        input logic                   i_reset,
        input logic                   i_psel,
        input logic                   i_penable,
        input logic                   i_pwrite,
        input rv_exec_pkg::apb_addr_t i_paddr,
        input logic                   o_pready,
        input logic                   i_illegal,
        input logic                   i_wb_valid
);
        timeunit 1ns;
        timeprecision 100ps;

        logic reg_first_access;

        // First access cycle of a register read
        assign reg_first_access = i_psel && i_penable && !i_pwrite &&
                ((i_paddr & ~12'h07f) == rv_exec_pkg::ADDR_REG_BASE);

        ready_in_access: assert property (@(posedge i_clock) disable iff (i_reset)
                o_pready |-> (i_psel && i_penable))
                else $error("o_pready high outside an access cycle");

        reg_read_two_cycles: assert property (@(posedge i_clock) disable iff (i_reset)
                (reg_first_access && $past(i_psel && !i_penable)) |-> !o_pready ##1 o_pready)
                else $error("register read did not complete on its second access cycle");

        no_wb_after_illegal: assert property (@(posedge i_clock) disable iff (i_reset)
                i_illegal |-> !i_wb_valid ##1 !i_wb_valid ##1 !i_wb_valid)
                else $error("register write right after an illegal instruction");

endmodule

bind rv_exec_top rv_exec_props props_i (
        .i_clock(i_clock), .i_reset(i_reset),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .o_pready(o_pready),
        .i_illegal(illegal), .i_wb_valid(wb_valid)
);

// File: rv_exec_tb.sv
module rv_exec_tb;
        timeunit 1ns;
        timeprecision 100ps;

        localparam int K_INSTR    = 0;   // Instruction write, then let it retire
        localparam int K_INSTR_NB = 1;   // Instruction write, next transfer follows at once
        localparam int K_READ     = 2;
        localparam int K_STATUS   = 3;
        localparam int NUM_RAND   = 3;
        localparam int RAND_XFERS = 18;  // APB transfers per random round

        typedef struct {
                int                     kind;
                rv_exec_pkg::apb_addr_t addr;
                rv_exec_pkg::xlen_t     data;
                rv_exec_pkg::xlen_t     exp;
        } entry_t;

        logic i_clock, i_reset, i_psel, i_penable, i_pwrite, o_pready;
        rv_exec_pkg::apb_addr_t i_paddr;
        rv_exec_pkg::xlen_t     i_pwdata, o_prdata;

        entry_t stim_q[$];
        int     value_errors = 0;
        int     other_errors = 0;
        int     cycles = 0;
        int     limit = 100000;

        tb_clock clock_i (.o_clock(i_clock), .o_reset(i_reset));

        rv_exec_top dut_i (
                .i_clock(i_clock), .i_reset(i_reset), .i_psel(i_psel),
                .i_penable(i_penable), .i_pwrite(i_pwrite), .i_paddr(i_paddr),
                .i_pwdata(i_pwdata), .o_prdata(o_prdata), .o_pready(o_pready)
        );

        always @(posedge i_clock) begin
                cycles <= cycles + 1;
                if (cycles >= limit) begin
                        $display("ERROR: run hung, no progress after %0d cycles", cycles);
                        $display("*** TEST FAILED ***");
                        $finish;
                end
        end

        function automatic rv_exec_pkg::xlen_t encode(logic [6:0] f7, rv_exec_pkg::reg_idx_t rs2,
                rv_exec_pkg::reg_idx_t rs1, logic [2:0] f3, rv_exec_pkg::reg_idx_t rd,
                logic [6:0] opc);
                return {f7, rs2, rs1, f3, rd, opc};
        endfunction

        function automatic rv_exec_pkg::xlen_t r_op(logic [6:0] f7, logic [2:0] f3,
                rv_exec_pkg::reg_idx_t rd, rv_exec_pkg::reg_idx_t rs1, rv_exec_pkg::reg_idx_t rs2);
                return encode(f7, rs2, rs1, f3, rd, 7'h33);
        endfunction

        function automatic rv_exec_pkg::xlen_t i_op(logic [2:0] f3, logic [11:0] imm,
                rv_exec_pkg::reg_idx_t rd, rv_exec_pkg::reg_idx_t rs1);
                return encode(imm[11:5], imm[4:0], rs1, f3, rd, 7'h13);
        endfunction

        function automatic rv_exec_pkg::apb_addr_t reg_addr(rv_exec_pkg::reg_idx_t n);
                return rv_exec_pkg::ADDR_REG_BASE + {5'b0, n, 2'b00};
        endfunction

        task automatic add(int kind, rv_exec_pkg::apb_addr_t addr, rv_exec_pkg::xlen_t data,
                rv_exec_pkg::xlen_t exp);
                entry_t e;
                e.kind = kind;
                e.addr = addr;
                e.data = data;
                e.exp  = exp;
                stim_q.push_back(e);
        endtask

        // Instruction plus its register, RESULT and STATUS checks
        task automatic add_op(rv_exec_pkg::xlen_t instr, rv_exec_pkg::reg_idx_t rd,
                rv_exec_pkg::xlen_t exp);
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, instr, '0);
                add(K_READ, reg_addr(rd), '0, exp);
                add(K_READ, rv_exec_pkg::ADDR_RESULT, '0, exp);
                add(K_STATUS, rv_exec_pkg::ADDR_STATUS, '0, {27'b0, rd});
        endtask

        task automatic check_word(string name, rv_exec_pkg::xlen_t got, rv_exec_pkg::xlen_t exp);
                if (got !== exp) begin
                        value_errors++;
                        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
                end
        endtask

        task automatic check_idx(string name, rv_exec_pkg::reg_idx_t got,
                rv_exec_pkg::reg_idx_t exp);
                if (got !== exp) begin
                        value_errors++;
                        $display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
                end
        endtask

        // Called at a falling edge, returns at the falling edge after completion
        task automatic apb_write(rv_exec_pkg::apb_addr_t addr, rv_exec_pkg::xlen_t data,
                output int stalls);
                stalls = 0;
                i_psel = 1'b1;
                i_pwrite = 1'b1;
                i_penable = 1'b0;
                i_paddr = addr;
                i_pwdata = data;
                @(negedge i_clock);
                i_penable = 1'b1;
                #10;
                while (!o_pready) begin
                        stalls++;
                        @(negedge i_clock);
                        #10;
                end
                @(negedge i_clock);
                i_psel = 1'b0;
                i_penable = 1'b0;
        endtask

        task automatic apb_read(rv_exec_pkg::apb_addr_t addr, output rv_exec_pkg::xlen_t data);
                i_psel = 1'b1;
                i_pwrite = 1'b0;
                i_penable = 1'b0;
                i_paddr = addr;
                @(negedge i_clock);
                i_penable = 1'b1;
                #10;
                while (!o_pready) begin
                        @(negedge i_clock);
                        #10;
                end
                data = o_prdata;   // Sampled mid-cycle, well clear of the edge
                @(negedge i_clock);
                i_psel = 1'b0;
                i_penable = 1'b0;
        endtask

        task automatic load_reg(rv_exec_pkg::reg_idx_t rd, rv_exec_pkg::xlen_t v);
                rv_exec_pkg::xlen_t seq [5];
                int stalls;
                seq[0] = i_op(3'd0, {1'b0, v[31:21]}, rd, 5'd0);   // ADDI
                seq[1] = i_op(3'd1, 12'd11, rd, rd);               // SLLI
                seq[2] = i_op(3'd6, {1'b0, v[20:10]}, rd, rd);     // ORI
                seq[3] = i_op(3'd1, 12'd10, rd, rd);
                seq[4] = i_op(3'd6, {2'b0, v[9:0]}, rd, rd);
                foreach (seq[k]) begin
                        apb_write(rv_exec_pkg::ADDR_INSTR, seq[k], stalls);
                        repeat (4) @(negedge i_clock);
                end
        endtask

        task automatic run_op(string name, rv_exec_pkg::xlen_t instr, rv_exec_pkg::xlen_t exp);
                rv_exec_pkg::xlen_t got;
                int stalls;
                apb_write(rv_exec_pkg::ADDR_INSTR, instr, stalls);
                repeat (4) @(negedge i_clock);
                apb_read(reg_addr(5'd10), got);
                check_word(name, got, exp);
        endtask

        initial begin
                rv_exec_pkg::xlen_t got, a, b;
                int stalls;
                int prev_nb;
                i_psel = 1'b0;
                i_penable = 1'b0;
                i_pwrite = 1'b0;
                i_paddr = '0;
                i_pwdata = '0;
                a = $urandom(32'ha57d9a70);

                // Reset values
                add(K_READ, reg_addr(5'd2), '0, 32'h0001_0400);
                add(K_READ, reg_addr(5'd0), '0, '0);
                add(K_READ, reg_addr(5'd1), '0, '0);
                add(K_READ, reg_addr(5'd31), '0, '0);
                add(K_STATUS, rv_exec_pkg::ADDR_STATUS, '0, '0);
                add(K_READ, rv_exec_pkg::ADDR_RESULT, '0, '0);
                // Operands x5 = -7, x6 = 3, x7 = 0x7ff
                add_op(i_op(3'd0, 12'hff9, 5'd5, 5'd0), 5'd5, 32'hffff_fff9);
                add_op(i_op(3'd0, 12'h003, 5'd6, 5'd0), 5'd6, 32'h0000_0003);
                add_op(i_op(3'd0, 12'h7ff, 5'd7, 5'd0), 5'd7, 32'h0000_07ff);
                // R-type
                add_op(r_op(7'h00, 3'd0, 5'd10, 5'd5, 5'd6), 5'd10, 32'hffff_fffc);
                add_op(r_op(7'h20, 3'd0, 5'd11, 5'd5, 5'd6), 5'd11, 32'hffff_fff6);
                add_op(r_op(7'h00, 3'd1, 5'd12, 5'd6, 5'd6), 5'd12, 32'h0000_0018);
                add_op(r_op(7'h00, 3'd2, 5'd13, 5'd5, 5'd6), 5'd13, 32'h0000_0001);
                add_op(r_op(7'h00, 3'd3, 5'd14, 5'd5, 5'd6), 5'd14, 32'h0000_0000);
                add_op(r_op(7'h00, 3'd4, 5'd15, 5'd5, 5'd6), 5'd15, 32'hffff_fffa);
                add_op(r_op(7'h00, 3'd5, 5'd16, 5'd5, 5'd6), 5'd16, 32'h1fff_ffff);
                add_op(r_op(7'h20, 3'd5, 5'd17, 5'd5, 5'd6), 5'd17, 32'hffff_ffff);
                add_op(r_op(7'h00, 3'd6, 5'd18, 5'd5, 5'd6), 5'd18, 32'hffff_fffb);
                add_op(r_op(7'h00, 3'd7, 5'd19, 5'd5, 5'd6), 5'd19, 32'h0000_0001);
                // I-type
                add_op(i_op(3'd0, 12'hffb, 5'd20, 5'd6), 5'd20, 32'hffff_fffe);
                add_op(i_op(3'd2, 12'hffa, 5'd21, 5'd5), 5'd21, 32'h0000_0001);
                add_op(i_op(3'd3, 12'hfff, 5'd22, 5'd6), 5'd22, 32'h0000_0001);
                add_op(i_op(3'd4, 12'hfff, 5'd23, 5'd5), 5'd23, 32'h0000_0006);
                add_op(i_op(3'd6, 12'h700, 5'd24, 5'd6), 5'd24, 32'h0000_0703);
                add_op(i_op(3'd7, 12'h0f0, 5'd25, 5'd7), 5'd25, 32'h0000_00f0);
                add_op(i_op(3'd1, 12'h01f, 5'd26, 5'd6), 5'd26, 32'h8000_0000);
                add_op(i_op(3'd5, 12'h01c, 5'd27, 5'd5), 5'd27, 32'h0000_000f);
                add_op(i_op(3'd5, 12'h401, 5'd28, 5'd5), 5'd28, 32'hffff_fffc);
                // x0 stays zero, and rs2 = x0 reads zero
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, i_op(3'd0, 12'h005, 5'd0, 5'd6), '0);
                add(K_READ, reg_addr(5'd0), '0, '0);
                add(K_READ, rv_exec_pkg::ADDR_RESULT, '0, 32'h0000_0008);
                add_op(r_op(7'h00, 3'd0, 5'd29, 5'd5, 5'd0), 5'd29, 32'hffff_fff9);
                // rs1 = x0 must not zero a live rs2
                add(K_INSTR_NB, rv_exec_pkg::ADDR_INSTR,
                    r_op(7'h20, 3'd0, 5'd30, 5'd0, 5'd5), '0);
                add(K_STATUS, rv_exec_pkg::ADDR_STATUS, '0, 32'h0000_011d);   // Still busy
                add(K_READ, reg_addr(5'd30), '0, 32'h0000_0007);
                add(K_READ, rv_exec_pkg::ADDR_RESULT, '0, 32'h0000_0007);
                // Illegal: load, branch, funct7 = 0x01
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, encode(7'h0, 5'd0, 5'd5, 3'd2, 5'd1, 7'h03), '0);
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, encode(7'h0, 5'd6, 5'd5, 3'd0, 5'd8, 7'h63), '0);
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, r_op(7'h01, 3'd0, 5'd1, 5'd5, 5'd6), '0);
                add(K_READ, reg_addr(5'd1), '0, '0);
                add(K_READ, reg_addr(5'd8), '0, '0);
                add(K_STATUS, rv_exec_pkg::ADDR_STATUS, '0, 32'h0003_001e);
                // Back-pressure on a dependent pair
                add(K_INSTR_NB, rv_exec_pkg::ADDR_INSTR, i_op(3'd0, 12'd100, 5'd8, 5'd0), '0);
                add(K_INSTR, rv_exec_pkg::ADDR_INSTR, i_op(3'd0, 12'd23, 5'd9, 5'd8), '0);
                add(K_READ, reg_addr(5'd8), '0, 32'd100);
                add(K_READ, reg_addr(5'd9), '0, 32'd123);

                limit = 20 + 10 * (stim_q.size() + NUM_RAND * RAND_XFERS);

                wait (!i_reset);
                @(negedge i_clock);
                prev_nb = 0;
                foreach (stim_q[n]) begin
                        case (stim_q[n].kind)
                        K_INSTR, K_INSTR_NB: begin
                                apb_write(stim_q[n].addr, stim_q[n].data, stalls);
                                if (prev_nb && stalls == 0) begin
                                        other_errors++;
                                        $display("ERROR: entry %0d was not held off while busy", n);
                                end
                                if (stim_q[n].kind == K_INSTR)
                                        repeat (4) @(negedge i_clock);
                        end
                        default: begin
                                apb_read(stim_q[n].addr, got);
                                check_word($sformatf("o_prdata @0x%03h", stim_q[n].addr),
                                           got, stim_q[n].exp);
                                if (stim_q[n].kind == K_STATUS)
                                        check_idx("status last rd", got[4:0], stim_q[n].exp[4:0]);
                        end
                        endcase
                        prev_nb = (stim_q[n].kind == K_INSTR_NB);
                end

                // Random operands in x3 and x4
                for (int r = 0; r < NUM_RAND; r++) begin
                        a = $urandom();
                        b = $urandom();
                        load_reg(5'd3, a);
                        load_reg(5'd4, b);
                        run_op("x10 add", r_op(7'h00, 3'd0, 5'd10, 5'd3, 5'd4), a + b);
                        run_op("x10 sub", r_op(7'h20, 3'd0, 5'd10, 5'd3, 5'd4), a - b);
                        run_op("x10 xor", r_op(7'h00, 3'd4, 5'd10, 5'd3, 5'd4), a ^ b);
                        run_op("x10 sltu", r_op(7'h00, 3'd3, 5'd10, 5'd3, 5'd4),
                               (a < b) ? 32'd1 : 32'd0);
                end

                $display("errors: %0d value mismatches, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("*** TEST PASSED ***");
                end else begin
                        $display("*** TEST FAILED ***");
                end
                $finish;
        end

endmodule

// File: rv_exec_top.sv
module rv_exec_top #(
        parameter rv_exec_pkg::xlen_t SP_RESET = 32'h0001_0400
) (
        input  logic                   i_clock,
        input  logic                   i_reset,
        input  logic                   i_psel,
        input  logic                   i_penable,
        input  logic                   i_pwrite,
        input  rv_exec_pkg::apb_addr_t i_paddr,
        input  rv_exec_pkg::xlen_t     i_pwdata,
        output rv_exec_pkg::xlen_t     o_prdata,
        output logic                   o_pready
);
        rv_exec_pkg::xlen_t    instr;
        logic                  instr_valid;
        logic                  view_req;
        rv_exec_pkg::reg_idx_t view_idx;
        logic [1:0]            rd_sel;
        logic                  illegal;
        logic                  wb_valid;
        rv_exec_pkg::reg_idx_t wb_rd;
        rv_exec_pkg::xlen_t    wb_data;
        rv_exec_pkg::xlen_t    view;

        exec_if exec_bus ();
        rf_if   rf_bus ();

        rv_apb_slave apb_i (
                .i_clock(i_clock), .i_reset(i_reset),
                .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
                .i_paddr(i_paddr), .i_pwdata(i_pwdata), .i_busy(exec_bus.busy),
                .o_pready(o_pready), .o_instr(instr), .o_instr_valid(instr_valid),
                .o_view_req(view_req), .o_view_idx(view_idx), .o_rd_sel(rd_sel)
        );

        rv_decode decode_i (
                .i_clock(i_clock), .i_reset(i_reset),
                .i_instr(instr), .i_instr_valid(instr_valid),
                .o_exec(exec_bus.dec), .o_illegal(illegal)
        );

        rv_execute execute_i (
                .i_clock(i_clock), .i_reset(i_reset),
                .i_exec(exec_bus.exe), .o_rf(rf_bus.exe),
                .o_wb_valid(wb_valid), .o_wb_rd(wb_rd), .o_wb_data(wb_data)
        );

        rv_regfile #(.SP_RESET(SP_RESET)) regfile_i (
                .i_clock(i_clock), .i_reset(i_reset),
                .i_view_req(view_req), .i_view_idx(view_idx),
                .i_rf(rf_bus.rf), .o_view(view)
        );

        rv_readback readback_i (
                .i_clock(i_clock), .i_reset(i_reset),
                .i_wb_valid(wb_valid), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
                .i_illegal(illegal), .i_busy(exec_bus.busy),
                .i_rd_sel(rd_sel), .i_view(view), .o_prdata(o_prdata)
        );

endmodule

// File: rv_execute.sv
module rv_execute (
        input  logic                  i_clock,
        input  logic                  i_reset,
        exec_if.exe                   i_exec,
        rf_if.exe                     o_rf,
        output logic                  o_wb_valid,
        output rv_exec_pkg::reg_idx_t o_wb_rd,
        output rv_exec_pkg::xlen_t    o_wb_data
);
        typedef enum logic [1:0] {IDLE, READ, WRITE} exec_state_e;

        exec_state_e        state;
        rv_exec_pkg::xlen_t op2;
        rv_exec_pkg::xlen_t alu_out;
        rv_exec_pkg::xlen_t result;

        assign i_exec.busy  = (state != IDLE);
        assign o_rf.read    = (state == IDLE) & i_exec.valid;
        assign o_rf.rs1_idx = i_exec.rs1;
        assign o_rf.rs2_idx = i_exec.rs2;

        assign op2 = i_exec.use_imm ? i_exec.imm : o_rf.rs2;

        always_comb begin
                case (i_exec.op)
                rv_exec_pkg::ALU_ADD:  alu_out = o_rf.rs1 + op2;
                rv_exec_pkg::ALU_SUB:  alu_out = o_rf.rs1 - op2;
                rv_exec_pkg::ALU_SLL:  alu_out = o_rf.rs1 << op2[4:0];
                rv_exec_pkg::ALU_SLT:  alu_out = {31'b0, $signed(o_rf.rs1) < $signed(op2)};
                rv_exec_pkg::ALU_SLTU: alu_out = {31'b0, o_rf.rs1 < op2};
                rv_exec_pkg::ALU_XOR:  alu_out = o_rf.rs1 ^ op2;
                rv_exec_pkg::ALU_SRL:  alu_out = o_rf.rs1 >> op2[4:0];
                rv_exec_pkg::ALU_SRA:  alu_out = $signed(o_rf.rs1) >>> op2[4:0];
                rv_exec_pkg::ALU_OR:   alu_out = o_rf.rs1 | op2;
                rv_exec_pkg::ALU_AND:  alu_out = o_rf.rs1 & op2;
                default:               alu_out = '0;
                endcase
        end

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        state <= IDLE;
                end else begin
                        case (state)
                        IDLE:    if (i_exec.valid) state <= READ;
                        READ:    state <= WRITE;   // Operands are on the ports now
                        default: state <= IDLE;
                        endcase
                end
        end

        always_ff @(posedge i_clock) begin
                if (state == READ)
                        result <= alu_out;
        end

        assign o_rf.write   = (state == WRITE);
        assign o_rf.wr_idx  = i_exec.rd;
        assign o_rf.wr_data = result;

        assign o_wb_valid = o_rf.write;
        assign o_wb_rd    = i_exec.rd;
        assign o_wb_data  = result;

endmodule

// File: rv_readback.sv
module rv_readback (
        input  logic                  i_clock,
        input  logic                  i_reset,
        input  logic                  i_wb_valid,
        input  rv_exec_pkg::reg_idx_t i_wb_rd,
        input  rv_exec_pkg::xlen_t    i_wb_data,
        input  logic                  i_illegal,
        input  logic                  i_busy,
        input  logic [1:0]            i_rd_sel,
        input  rv_exec_pkg::xlen_t    i_view,
        output rv_exec_pkg::xlen_t    o_prdata
);
        rv_exec_pkg::xlen_t    last_result;
        rv_exec_pkg::reg_idx_t last_rd;
        logic [7:0]            illegal_cnt;
        rv_exec_pkg::xlen_t    status;

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        last_result <= '0;
                        last_rd     <= '0;
                        illegal_cnt <= '0;
                end else begin
                        if (i_wb_valid) begin
                                last_result <= i_wb_data;
                                last_rd     <= i_wb_rd;
                        end
                        if (i_illegal && illegal_cnt != 8'hff)
                                illegal_cnt <= illegal_cnt + 8'd1;   // Saturates
                end
        end

        assign status = {8'b0, illegal_cnt, 7'b0, i_busy, 3'b0, last_rd};

        always_comb begin
                case (i_rd_sel)
                rv_exec_pkg::SEL_RESULT: o_prdata = last_result;
                rv_exec_pkg::SEL_STATUS: o_prdata = status;
                rv_exec_pkg::SEL_REG:    o_prdata = i_view;
                default:                 o_prdata = '0;
                endcase
        end

endmodule

// File: rv_regfile.sv
module rv_regfile #(
        parameter rv_exec_pkg::xlen_t SP_RESET = 32'h0001_0400
) (
        input  logic                  i_clock,
        input  logic                  i_reset,
        input  logic                  i_view_req,
        input  rv_exec_pkg::reg_idx_t i_view_idx,
        rf_if.rf                      i_rf,
        output rv_exec_pkg::xlen_t    o_view
);
        rv_exec_pkg::xlen_t regs [32];

        always_ff @(posedge i_clock or posedge i_reset) begin
                if (i_reset) begin
                        for (int i = 0; i < 32; i++)
                                regs[i] <= (i == 2) ? SP_RESET : '0;   // x2 is sp
                end else if (i_rf.write && i_rf.wr_idx != '0) begin
                        regs[i_rf.wr_idx] <= i_rf.wr_data;
                end
        end

        // Registered reads, x0 forced to zero on every port
        always_ff @(posedge i_clock) begin
                if (i_rf.read) begin
                        i_rf.rs1 <= (i_rf.rs1_idx != '0) ? regs[i_rf.rs1_idx] : '0;
                        i_rf.rs2 <= (i_rf.rs2_idx != '0) ? regs[i_rf.rs2_idx] : '0;
                end
                if (i_view_req)
                        o_view <= (i_view_idx != '0) ? regs[i_view_idx] : '0;
        end

endmodule

// File: tb_clock.sv
module tb_clock (
        output logic o_clock,
        output logic o_reset
);
        timeunit 1ns;
        timeprecision 100ps;

        initial begin
                o_clock = 1'b0;
                forever #50 o_clock = ~o_clock;   // 100 ns period
        end

        initial begin
                o_reset = 1'b1;
                repeat (4) @(posedge o_clock);
                @(negedge o_clock);
                o_reset = 1'b0;
        end

endmodule
